/* all.f */
hw/dma_ctrl_pkg.sv
hw/axil_write_port.sv
hw/dma_cmd_sequencer.sv
hw/chunk_walker.sv
hw/dma_ctrl_top.sv
sim/dma_engine_model.sv
sim/dma_ctrl_properties.sv
sim/tb_dma_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build and run the DMA controller testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module tb_dma_ctrl \
    -f all.f -o tb_dma_ctrl > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/tb_dma_ctrl > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "run reported a failure"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "run ended without finishing the tests"; exit 1; }
exit 0

/* sim/tb_dma_ctrl.sv */
// DMA controller testbench
`timescale 1ns/1ps

module tb_dma_ctrl;
    import dma_ctrl_pkg::*;

    localparam int TOTAL_CHUNKS = 18;
    localparam int TIMEOUT_CYCLES = TOTAL_CHUNKS * 400;

    logic         clk;
    logic         rst;
    dma_job_t     job;
    logic         job_req;
    logic         job_ack;
    logic         irq;
    addr_t        awaddr;
    logic         awvalid;
    logic         awready;
    data_t        wdata;
    logic [3:0]   wstrb;
    logic         wvalid;
    logic         wready;
    logic         bvalid;
    logic         bready;
    logic         heavy;
    logic         slow_irq;
    axil_wr_req_t log_entry;
    logic         log_valid;
    int           early_clears;
    axil_wr_req_t log_q[$];
    addr_t        addr_q[$];
    logic [3:0]   strb_q[$];
    int           data_first;
    int           cycles;

    dma_ctrl_top UUT (
        .clk(clk), .rst(rst), .job(job), .job_req(job_req), .job_ack(job_ack), .irq(irq),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready), .wdata(wdata), .wstrb(wstrb),
        .wvalid(wvalid), .wready(wready), .bvalid(bvalid), .bready(bready)
    );

    dma_engine_model engine (
        .clk(clk), .rst(rst), .heavy(heavy), .slow_irq(slow_irq), .awaddr(awaddr),
        .awvalid(awvalid), .awready(awready), .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid),
        .wready(wready), .bvalid(bvalid), .bready(bready), .irq(irq), .log_entry(log_entry),
        .log_valid(log_valid), .early_clears(early_clears)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        if (log_valid) log_q.push_back(log_entry);
        if (awvalid && awready) addr_q.push_back(awaddr);
        if (wvalid && wready) strb_q.push_back(wstrb);
        // data taken while the address still waits
        if (heavy && wvalid && wready && awvalid && !awready) data_first++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            stop_with_failure("timeout: the controller stopped making progress");
        end
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_offset(input reg_off_t got, input reg_off_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error at %0t: offset 0x%h, expected 0x%h",
                                        $time, got, exp));
        end
    endtask

    task automatic check_data(input data_t got, input data_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error at %0t: data 0x%h, expected 0x%h",
                                        $time, got, exp));
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error at %0t: awaddr 0x%h, expected 0x%h",
                                        $time, got, exp));
        end
    endtask

    task automatic check_strobe(input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("error at %0t: wstrb %b, expected %b",
                                        $time, got, exp));
        end
    endtask

    task automatic expect_write(input reg_off_t off, input data_t data);
        axil_wr_req_t e;
        if (log_q.size() == 0 || addr_q.size() == 0 || strb_q.size() == 0) begin
            stop_with_failure("a register write is missing from the log");
        end else begin
            e = log_q.pop_front();
            check_offset(e.offset, off);
            check_data(e.data, data);
            check_addr(addr_q.pop_front(), addr_t'(off)); // offset zero-extended
            check_strobe(strb_q.pop_front(), 4'b1111);
        end
    endtask

    function automatic dma_job_t make_job(input addr_t ext, input addr_t loc, input count_t ett,
                                          input count_t y_lim, input count_t z_lim,
                                          input count_t y_step, input count_t z_step,
                                          input dir_e dir);
        dma_job_t j;
        j = '0;
        j.ext_base = ext;
        j.local_base = loc;
        j.ett = ett;
        j.y_lim = y_lim;
        j.z_lim = z_lim;
        j.y_step = y_step;
        j.z_step = z_step;
        j.dir = dir;
        return j;
    endfunction

    task automatic wait_for_ack(input logic level);
        while (job_ack !== level) begin
            @(posedge clk);
            #1;
        end
    endtask

    // full four-phase exchange on the job port
    task automatic run_job(input dma_job_t j);
        @(posedge clk);
        #1;
        job = j;
        job_req = 1'b1;
        wait_for_ack(1'b1);
        repeat (2) @(posedge clk);
        #1;
        if (!job_ack) begin
            stop_with_failure("job_ack dropped while job_req was still high");
        end else begin
            job_req = 1'b0;
            wait_for_ack(1'b0);
        end
    endtask

    // expected writes from the chunk rules, y inner and z outer
    task automatic check_job_writes(input dma_job_t j);
        addr_t btt;
        addr_t ext;
        addr_t loc;
        int    n;
        int    y;
        int    z;
        btt = addr_t'(j.ett) * ELEM_BYTES;
        n = 0;
        for (z = 0; z <= int'(j.z_lim); z++) begin
            for (y = 0; y <= int'(j.y_lim); y++) begin
                ext = j.ext_base + addr_t'(y * int'(j.y_step)) + addr_t'(z * int'(j.z_step));
                loc = LOCAL_SRAM_BASE + j.local_base + addr_t'(n) * btt;
                expect_write(REG_IRQ_MASK, IRQ_BOTH);
                expect_write(REG_BTT, btt);
                expect_write(REG_READER_ADDR, (j.dir == DIR_BRING) ? ext : loc);
                expect_write(REG_WRITER_ADDR, (j.dir == DIR_BRING) ? loc : ext);
                expect_write(REG_CONTROL, CTRL_START_BOTH);
                expect_write(REG_IRQ_STATUS, IRQ_BOTH);
                n++;
            end
        end
        if (log_q.size() != 0 || addr_q.size() != 0 || strb_q.size() != 0) begin
            stop_with_failure("more register writes than the job needs");
        end else if (early_clears != 0) begin
            stop_with_failure("interrupt status was cleared while irq was low");
        end
    endtask

    task automatic test_single_bring();
        dma_job_t j;
        j = make_job(32'h8000_1000, 32'h0000_0200, 16'd64, 16'd0, 16'd0, 16'd0, 16'd0, DIR_BRING);
        run_job(j);
        check_job_writes(j);
    endtask

    task automatic test_send_swap();
        dma_job_t j;
        j = make_job(32'h8002_0000, 32'h0000_0100, 16'd32, 16'd0, 16'd0, 16'd0, 16'd0, DIR_SEND);
        run_job(j);
        check_job_writes(j);
    endtask

    task automatic test_walk_3x2();
        dma_job_t j;
        j = make_job(32'h9000_0000, 32'h0000_0400, 16'd16, 16'd2, 16'd1,
                     16'h0200, 16'h1000, DIR_BRING);
        run_job(j);
        check_job_writes(j);
    endtask

    task automatic test_heavy_stalls();
        dma_job_t j;
        heavy = 1'b1; // address ready rarer than data ready
        j = make_job(32'hA000_0040, 32'h0000_0800, 16'd8, 16'd2, 16'd1,
                     16'h0100, 16'h0800, DIR_SEND);
        run_job(j);
        check_job_writes(j);
        heavy = 1'b0;
        if (data_first == 0) begin
            stop_with_failure("the stalls never let data through ahead of its address");
        end
    endtask

    task automatic test_slow_irq_back_to_back();
        dma_job_t a;
        dma_job_t b;
        slow_irq = 1'b1;
        a = make_job(32'h8100_0000, 32'h0000_0000, 16'd4, 16'd1, 16'd0,
                     16'h0040, 16'h0000, DIR_BRING);
        b = make_job(32'h8200_0000, 32'h0000_1000, 16'd12, 16'd0, 16'd1,
                     16'h0000, 16'h0400, DIR_SEND);
        run_job(a);
        check_job_writes(a);
        run_job(b);
        check_job_writes(b);
        slow_irq = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        job = '0;
        job_req = 1'b0;
        heavy = 1'b0;
        slow_irq = 1'b0;
        data_first = 0;
        cycles = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        test_single_bring();
        test_send_swap();
        test_walk_3x2();
        test_heavy_stalls();
        test_slow_irq_back_to_back();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* sim/dma_ctrl_properties.sv */
// handshake assertions
`timescale 1ns/1ps

module dma_ctrl_properties (
    input logic                       clk,
    input logic                       rst,
    input logic                       awvalid,
    input logic                       awready,
    input logic                       wvalid,
    input logic                       wready,
    input logic                       bvalid,
    input logic                       bready,
    input logic                       wr_req,
    input logic                       wr_ack,
    input dma_ctrl_pkg::axil_wr_req_t wr
);
    import dma_ctrl_pkg::*;

    logic aw_done;      // address taken for the open write
    logic w_done;
    logic ctrl_written; // start issued, clear still due

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else if (bvalid && bready) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                aw_done <= 1'b1;
            end
            if (wvalid && wready) begin
                w_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_written <= 1'b0;
        end else if (wr_req && wr_ack) begin
            if (wr.offset == REG_CONTROL) begin
                ctrl_written <= 1'b1;
            end else if (wr.offset == REG_IRQ_STATUS) begin
                ctrl_written <= 1'b0;
            end
        end
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");

    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");

    a_ack_req: assert property (@(posedge clk) disable iff (rst)
        $rose(wr_ack) |-> wr_req)
        else $error("wr_ack rose without wr_req");

    // both channels must be done first
    a_bready: assert property (@(posedge clk) disable iff (rst)
        bready |-> aw_done && w_done)
        else $error("bready raised before address and data were accepted");

    a_clear: assert property (@(posedge clk) disable iff (rst)
        $rose(wr_req) && wr.offset == REG_IRQ_STATUS |-> ctrl_written)
        else $error("interrupt clear issued before the control write");

endmodule

bind dma_ctrl_top dma_ctrl_properties u_props (
    .clk     (clk),
    .rst     (rst),
    .awvalid (awvalid),
    .awready (awready),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready),
    .wr_req  (wr_req),
    .wr_ack  (wr_ack),
    .wr      (wr)
);

/* sim/dma_engine_model.sv */
// DMA engine register model
`timescale 1ns/1ps

module dma_engine_model (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        heavy,    // more address stalls
    input  logic                        slow_irq,
    input  dma_ctrl_pkg::addr_t         awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  dma_ctrl_pkg::data_t         wdata,
    input  logic [3:0]                  wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic                        bvalid,
    input  logic                        bready,
    output logic                        irq,
    output dma_ctrl_pkg::axil_wr_req_t  log_entry,
    output logic                        log_valid,
    output int                          early_clears
);
    import dma_ctrl_pkg::*;

    logic [15:0] lfsr;
    logic        got_addr;
    logic        got_data;
    logic        resp_pend;
    logic        log_next;
    logic        irq_next;
    logic        stall_more; // heavy as seen at the edge
    reg_off_t    off_q;
    data_t       data_q;
    int          irq_count; // 0 when no irq pending
    logic        b0;
    logic        b1;
    logic        b2;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b = lfsr[0];
    endtask

    initial begin
        lfsr = 16'd19335;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        irq = 1'b0;
        irq_next = 1'b0;
        log_entry = '0;
        log_valid = 1'b0;
        early_clears = 0;
        got_addr = 1'b0;
        got_data = 1'b0;
        resp_pend = 1'b0;
        irq_count = 0;
        forever begin
            @(posedge clk);
            log_next = 1'b0;
            stall_more = heavy;
            if (rst) begin
                got_addr = 1'b0;
                got_data = 1'b0;
                resp_pend = 1'b0;
                irq_count = 0;
                irq_next = 1'b0;
            end else begin
                if (awvalid && awready) begin
                    got_addr = 1'b1;
                    off_q = awaddr[5:0];
                end
                if (wvalid && wready) begin
                    got_data = 1'b1;
                    // byte lanes follow the strobes
                    data_q = wdata & {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
                end
                if (bvalid && bready) resp_pend = 1'b0;
                if (got_addr && got_data) begin
                    got_addr = 1'b0;
                    got_data = 1'b0;
                    resp_pend = 1'b1;
                    log_next = 1'b1;
                    if (off_q == REG_CONTROL) begin
                        take_bit(b0);
                        take_bit(b1);
                        take_bit(b2);
                        irq_count = int'({b2, b1, b0}) + 1 + (slow_irq ? 32 : 0);
                    end
                    if (off_q == REG_IRQ_STATUS) begin
                        if (!irq) early_clears++;
                        irq_next = 1'b0; // write clears the level
                    end
                end
                if (irq_count > 0) begin
                    irq_count--;
                    if (irq_count == 0) irq_next = 1'b1;
                end
            end
            #1;
            irq = irq_next;
            log_valid = log_next;
            log_entry = '{offset: off_q, data: data_q};
            take_bit(b0);
            if (stall_more) begin
                take_bit(b1);
                b0 = b0 & b1;
            end
            awready = !rst && !got_addr && b0;
            take_bit(b0);
            wready = !rst && !got_data && b0;
            take_bit(b0);
            bvalid = resp_pend && (bvalid || b0); // held until bready
        end
    end

endmodule

/* hw/dma_ctrl_top.sv */
// DMA controller top
`timescale 1ns/1ps

module dma_ctrl_top (
    input  logic                   clk,
    input  logic                   rst,

    input  dma_ctrl_pkg::dma_job_t job,
    input  logic                   job_req,
    output logic                   job_ack,

    input  logic                   irq, // merged reader/writer interrupt

    output dma_ctrl_pkg::addr_t    awaddr,
    output logic                   awvalid,
    input  logic                   awready,
    output dma_ctrl_pkg::data_t    wdata,
    output logic [3:0]             wstrb,
    output logic                   wvalid,
    input  logic                   wready,
    input  logic                   bvalid,
    output logic                   bready
);
    import dma_ctrl_pkg::*;

    chunk_cmd_t   cmd;
    logic         cmd_req;
    logic         cmd_ack;

    axil_wr_req_t wr;
    logic         wr_req;
    logic         wr_ack;

    chunk_walker u_walker (
        .clk     (clk),
        .rst     (rst),
        .job     (job),
        .job_req (job_req),
        .job_ack (job_ack),
        .cmd     (cmd),
        .cmd_req (cmd_req),
        .cmd_ack (cmd_ack)
    );

    dma_cmd_sequencer u_sequencer (
        .clk     (clk),
        .rst     (rst),
        .cmd     (cmd),
        .cmd_req (cmd_req),
        .cmd_ack (cmd_ack),
        .irq     (irq),
        .wr      (wr),
        .wr_req  (wr_req),
        .wr_ack  (wr_ack)
    );

    axil_write_port u_write_port (
        .clk     (clk),
        .rst     (rst),
        .wr      (wr),
        .wr_req  (wr_req),
        .wr_ack  (wr_ack),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

/* hw/chunk_walker.sv */
// strided chunk walker
`timescale 1ns/1ps

module chunk_walker (
    input  logic                     clk,
    input  logic                     rst,

    input  dma_ctrl_pkg::dma_job_t   job,
    input  logic                     job_req,
    output logic                     job_ack,

    output dma_ctrl_pkg::chunk_cmd_t cmd,
    output logic                     cmd_req,
    input  logic                     cmd_ack
);
    import dma_ctrl_pkg::*;

    typedef enum logic [1:0] {
        WLK_IDLE,
        WLK_REQ,
        WLK_DROP,
        WLK_DONE
    } walk_state_e;

    walk_state_e state;
    dma_job_t    job_q;

    count_t y;
    count_t z;
    count_t n; // chunk index

    addr_t btt;
    addr_t ext_addr;
    addr_t local_addr;
    logic  last_chunk;

    assign btt = addr_t'(job_q.ett) * ELEM_BYTES;

    assign ext_addr = job_q.ext_base
                    + addr_t'(y) * addr_t'(job_q.y_step)
                    + addr_t'(z) * addr_t'(job_q.z_step);

    // local side moves by btt per chunk
    assign local_addr = LOCAL_SRAM_BASE + job_q.local_base + addr_t'(n) * btt;

    assign last_chunk = (y == job_q.y_lim) && (z == job_q.z_lim);

    always_comb begin
        cmd.btt = btt;
        if (job_q.dir == DIR_BRING) begin
            cmd.reader_addr = ext_addr;
            cmd.writer_addr = local_addr;
        end else begin
            cmd.reader_addr = local_addr; // send swaps sides
            cmd.writer_addr = ext_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= WLK_IDLE;
            cmd_req <= 1'b0;
            job_ack <= 1'b0;
        end else begin
            case (state)
                WLK_IDLE: begin
                    if (job_req) begin
                        job_q   <= job;
                        y       <= '0;
                        z       <= '0;
                        n       <= '0;
                        cmd_req <= 1'b1;
                        state   <= WLK_REQ;
                    end
                end

                WLK_REQ: begin
                    if (cmd_ack) begin
                        cmd_req <= 1'b0;
                        state   <= WLK_DROP;
                    end
                end

                WLK_DROP: begin
                    if (!cmd_ack) begin
                        if (last_chunk) begin
                            job_ack <= 1'b1;
                            state   <= WLK_DONE;
                        end else begin
                            // y inner, z outer
                            if (y == job_q.y_lim) begin
                                y <= '0;
                                z <= z + 1'b1;
                            end else begin
                                y <= y + 1'b1;
                            end
                            n       <= n + 1'b1;
                            cmd_req <= 1'b1;
                            state   <= WLK_REQ;
                        end
                    end
                end

                WLK_DONE: begin
                    if (!job_req) begin
                        job_ack <= 1'b0;
                        state   <= WLK_IDLE;
                    end
                end

                default: state <= WLK_IDLE;
            endcase
        end
    end

endmodule

/* hw/dma_cmd_sequencer.sv */
// DMA chunk register sequencer
`timescale 1ns/1ps

module dma_cmd_sequencer (
    input  logic                       clk,
    input  logic                       rst,

    input  dma_ctrl_pkg::chunk_cmd_t   cmd,
    input  logic                       cmd_req,
    output logic                       cmd_ack,

    input  logic                       irq,

    output dma_ctrl_pkg::axil_wr_req_t wr,
    output logic                       wr_req,
    input  logic                       wr_ack
);
    import dma_ctrl_pkg::*;

    seq_state_e state;
    seq_state_e next_state; // follows the current write
    logic       write_done;

    // register write for the current step
    always_comb begin
        wr.offset = REG_IRQ_MASK;
        wr.data   = IRQ_BOTH;
        case (state)
            SEQ_BTT: begin
                wr.offset = REG_BTT;
                wr.data   = cmd.btt;
            end
            SEQ_READER: begin
                wr.offset = REG_READER_ADDR;
                wr.data   = cmd.reader_addr;
            end
            SEQ_WRITER: begin
                wr.offset = REG_WRITER_ADDR;
                wr.data   = cmd.writer_addr;
            end
            SEQ_START: begin
                wr.offset = REG_CONTROL;
                wr.data   = CTRL_START_BOTH;
            end
            SEQ_CLEAR: begin
                wr.offset = REG_IRQ_STATUS;
                wr.data   = IRQ_BOTH; // write-one-to-clear
            end
            default: begin
            end
        endcase
    end

    // fixed programming order
    always_comb begin
        case (state)
            SEQ_MASK:   next_state = SEQ_BTT;
            SEQ_BTT:    next_state = SEQ_READER;
            SEQ_READER: next_state = SEQ_WRITER;
            SEQ_WRITER: next_state = SEQ_START;
            SEQ_START:  next_state = SEQ_WAIT_IRQ;
            SEQ_CLEAR:  next_state = SEQ_ACK;
            default:    next_state = SEQ_IDLE;
        endcase
    end

    // req already dropped and ack returned low
    assign write_done = !wr_req && !wr_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= SEQ_IDLE;
            wr_req  <= 1'b0;
            cmd_ack <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (cmd_req) begin
                        state  <= SEQ_MASK;
                        wr_req <= 1'b1;
                    end
                end

                SEQ_WAIT_IRQ: begin
                    if (irq) begin
                        state  <= SEQ_CLEAR;
                        wr_req <= 1'b1;
                    end
                end

                SEQ_ACK: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;
                        state   <= SEQ_IDLE;
                    end
                end

                default: begin // one of the register writes
                    if (wr_req && wr_ack) begin
                        wr_req <= 1'b0;
                    end else if (write_done) begin
                        state <= next_state;
                        if (next_state == SEQ_ACK) begin
                            cmd_ack <= 1'b1; // chunk finished after clear
                        end else if (next_state != SEQ_WAIT_IRQ) begin
                            wr_req <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

/* hw/axil_write_port.sv */
// AXI4-Lite single write master
`timescale 1ns/1ps

module axil_write_port (
    input  logic                       clk,
    input  logic                       rst,

    input  dma_ctrl_pkg::axil_wr_req_t wr,
    input  logic                       wr_req,
    output logic                       wr_ack,

    output dma_ctrl_pkg::addr_t        awaddr,
    output logic                       awvalid,
    input  logic                       awready,
    output dma_ctrl_pkg::data_t        wdata,
    output logic [3:0]                 wstrb,
    output logic                       wvalid,
    input  logic                       wready,
    input  logic                       bvalid,
    output logic                       bready
);
    import dma_ctrl_pkg::*;

    logic active;    // write in progress
    logic addr_sent;
    logic data_sent;

    // payload held by the requester while wr_req is up
    assign awaddr = addr_t'(wr.offset);
    assign wdata  = wr.data;
    assign wstrb  = '1;

    // each channel drops on its own ready
    assign awvalid = active && !addr_sent;
    assign wvalid  = active && !data_sent;

    assign bready = active && addr_sent && data_sent;

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            addr_sent <= 1'b0;
            data_sent <= 1'b0;
            wr_ack    <= 1'b0;
        end else begin
            // new request only once the previous ack has gone low
            if (!active && wr_req && !wr_ack) begin
                active <= 1'b1;
            end

            if (awvalid && awready) begin
                addr_sent <= 1'b1;
            end
            if (wvalid && wready) begin
                data_sent <= 1'b1;
            end

            if (bvalid && bready) begin
                active    <= 1'b0;
                addr_sent <= 1'b0;
                data_sent <= 1'b0;
                wr_ack    <= 1'b1;
            end

            if (wr_ack && !wr_req) begin
                wr_ack <= 1'b0; // four-phase return
            end
        end
    end

endmodule

/* hw/dma_ctrl_pkg.sv */
// DMA controller shared types
package dma_ctrl_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [5:0]  reg_off_t;
    typedef logic [15:0] count_t;

    // engine register map
    localparam reg_off_t REG_CONTROL     = 6'h00;
    localparam reg_off_t REG_IRQ_MASK    = 6'h04;
    localparam reg_off_t REG_IRQ_STATUS  = 6'h0C;
    localparam reg_off_t REG_READER_ADDR = 6'h10;
    localparam reg_off_t REG_WRITER_ADDR = 6'h20;
    localparam reg_off_t REG_BTT         = 6'h30;

    localparam addr_t ELEM_BYTES      = 32'd2;
    localparam addr_t LOCAL_SRAM_BASE = 32'h4000_0000; // local SRAM window
    localparam data_t CTRL_START_BOTH = 32'h0000_0003; // reader + writer start
    localparam data_t IRQ_BOTH        = 32'h0000_0003; // mask and clear share bits

    typedef enum logic {
        DIR_BRING = 1'b0, // ext -> local
        DIR_SEND  = 1'b1  // local -> ext
    } dir_e;

    typedef struct packed {
        addr_t      ext_base;
        addr_t      local_base;
        count_t     ett;      // elements per chunk
        count_t     y_lim;
        count_t     z_lim;
        count_t     y_step;   // bytes
        count_t     z_step;   // bytes
        logic [6:0] pad;
        dir_e       dir;
    } dma_job_t;

    typedef struct packed {
        addr_t reader_addr;
        addr_t writer_addr;
        addr_t btt;
    } chunk_cmd_t;

    typedef struct packed {
        reg_off_t offset;
        data_t    data;
    } axil_wr_req_t;

    typedef enum logic [3:0] {
        SEQ_IDLE,
        SEQ_MASK,
        SEQ_BTT,
        SEQ_READER,
        SEQ_WRITER,
        SEQ_START,
        SEQ_WAIT_IRQ,
        SEQ_CLEAR,
        SEQ_ACK
    } seq_state_e;

endpackage
